// ==== build.f ====
+incdir+include
logic/st_map_pkg.sv
logic/st_bus_pkg.sv
logic/slot_sequencer.sv
logic/address_decoder.sv
logic/bus_cycle_ctrl.sv
logic/irq_encoder.sv
logic/st_bus_glue.sv
verif/st_bus_glue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the st bus glue testbench with verilator
# a failing run is found by searching the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module st_bus_glue_tb \
	-Mdir obj_dir -o st_bus_glue_sim > build.log 2>&1 &&
	./obj_dir/st_bus_glue_sim > sim.log 2>&1 ||
	{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
	{ echo "simulation passed"; exit 0; }

// ==== verif/st_bus_glue_tb.sv ====
// st bus glue testbench
// random decode, bus error, bus request and interrupt checks against
// a reference model of the memory map, autovectors and ipl priority
`timescale 1ns/1ps
`default_nettype none
`include "st_consts.svh"

module st_bus_glue_tb
	import st_map_pkg::*;
	import st_bus_pkg::*;
();

	localparam int N_DECODE    = 48;
	// decode, bus error, bus request and acknowledge accesses
	localparam int N_ACCESS    = N_DECODE + 4 + 2 + 3;
	localparam int HOLD        = 300;
	// reset, bus request holds and blank pulses
	localparam int IDLE_CYCLES = 10 + 2 * HOLD + 400;
	localparam int CYCLE_LIMIT = N_ACCESS * 16 * 16 + IDLE_CYCLES + 200;

	// i/o offsets tried in the $ff page, the last one hits no register
	localparam logic [15:0] IO_BASES [16] = '{
		16'h8000, 16'h8200, 16'h820e, 16'h8240, 16'h8604, 16'h8608, 16'h860e, 16'h8800,
		16'h8900, 16'h8a00, 16'h8e00, 16'h8e20, 16'h9200, 16'hfa00, 16'hfc00, 16'h8100
	};

	logic        clk_32;
	logic        berr_reset;
	st_config_t  cfg;
	logic        access_req;
	cpu_access_t access;
	logic        bus_request;
	logic        st_vs;
	logic        st_hs;
	logic        mfp_irq;
	logic        done;
	completion_t result;
	logic [2:0]  ipl;
	logic        mfp_iack;

	// expected completions, in request order
	completion_t exp_q[$];
	completion_t mon_exp;
	// stimulus side and monitor side counters
	int          errors = 0;
	int          checks = 0;
	int          mon_errors = 0;
	int          mon_checks = 0;
	int          cycle_cnt = 0;
	int          cycles;
	int          mark;
	// model of the blank latches
	logic        vbi_set;
	logic        hbi_set;

	initial begin
		clk_32 = 1'b0;
		forever #4 clk_32 = ~clk_32;
	end

	st_bus_glue dut_i (
		.clk_32      (clk_32),
		.berr_reset  (berr_reset),
		.cfg         (cfg),
		.access_req  (access_req),
		.access      (access),
		.bus_request (bus_request),
		.st_vs       (st_vs),
		.st_hs       (st_hs),
		.mfp_irq     (mfp_irq),
		.done        (done),
		.result      (result),
		.ipl         (ipl),
		.mfp_iack    (mfp_iack)
	);

	// $ff page registers, windows in byte offsets
	function automatic target_e ref_io(input st_config_t c, input cpu_access_t a,
		input logic [15:0] o);
		logic mste;
		mste = c.mega_ste && !c.steroids;
		if (o inside {[16'h8000:16'h800d]})
			return tgt_mmu;
		if (o inside {[16'h8200:16'h820d], [16'h8240:16'h827f]} ||
			(c.ste && o inside {[16'h820e:16'h820f]}))
			return tgt_shifter;
		// dma word register wants both byte lanes
		if ((!a.uds_n && !a.lds_n && o inside {[16'h8604:16'h8607]}) ||
			o inside {[16'h8608:16'h860d]} || (c.ste && o inside {[16'h860e:16'h860f]}))
			return tgt_dma;
		if (o inside {[16'h8800:16'h88ff]})
			return tgt_psg;
		if (c.ste && o inside {[16'h8900:16'h893f]})
			return tgt_ste_snd;
		if ((c.blitter || c.ste) && o inside {[16'h8a00:16'h8a3f]})
			return tgt_blitter;
		if (mste && o inside {[16'h8e00:16'h8e0f]})
			return tgt_vme;
		if (mste && o inside {[16'h8e20:16'h8e21]})
			return tgt_mste_ctrl;
		if (c.ste && o inside {[16'h9200:16'h923f]})
			return tgt_ste_joy;
		if (!a.lds_n && o inside {[16'hfa00:16'hfa3f]})
			return tgt_mfp;
		if (o inside {[16'hfc00:16'hfdff]})
			return tgt_acia;
		return tgt_none;
	endfunction

	// expected completion of one access under a configuration
	function automatic completion_t ref_decode(input st_config_t c, input cpu_access_t a);
		logic [23:0] b;
		target_e     t;
		completion_t r;
		b = {a.addr, 1'b0};
		t = tgt_none;
		if (a.fc == 3'd7) begin
			if (a.addr[2:0] == 3'd6)
				t = tgt_iack_mfp;
			else if (a.addr[2:0] == 3'd4)
				t = tgt_iack_vbi;
			else if (a.addr[2:0] == 3'd2)
				t = tgt_iack_hbi;
		end else if (b <= 24'h000007 ||
			b inside {[24'he00000:24'he3ffff], [24'hfc0000:24'hfeffff]}) begin
			if (a.rw)
				t = tgt_rom;
		end else if (b < 24'h400000) begin
			t = tgt_ram;
		end else if (b < 24'h800000) begin
			if (c.mem_size inside {mem_8m, mem_14m})
				t = tgt_ram;
		end else if (b < 24'he00000) begin
			if (c.mem_size == mem_14m)
				t = tgt_ram;
		end else if (b inside {[24'he80000:24'hefffff]}) begin
			if (c.steroids)
				t = tgt_ram;
		end else if (b inside {[24'hfa0000:24'hfbffff]}) begin
			if (a.rw)
				t = c.ethernec ? tgt_romport : tgt_rom;
		end else if (b[23:16] == 8'hff) begin
			t = ref_io(c, a, b[15:0]);
		end
		// idle cycles never touch the bus
		if (a.busstate == bs_idle)
			t = tgt_none;
		r.berr   = (t == tgt_none) && (a.busstate != bs_idle);
		r.target = t;
		r.vector = (t == tgt_iack_vbi) ? `ST_VEC_VBI :
			(t == tgt_iack_hbi) ? `ST_VEC_HBI : 8'h00;
		return r;
	endfunction

	function automatic logic [2:0] ref_ipl(input logic mfp, input logic vbi, input logic hbi);
		if (mfp)
			return `ST_IPL_MFP;
		if (vbi)
			return `ST_IPL_VBI;
		if (hbi)
			return `ST_IPL_HBI;
		return `ST_IPL_NONE;
	endfunction

	task automatic check_completion(input completion_t got, input completion_t exp,
		input string what);
		target_e gt;
		target_e et;
		gt = got.target;
		et = exp.target;
		mon_checks++;
		if (got !== exp) begin
			mon_errors++;
			$display("Error at %0t: %s berr %b target %s vector %h, expected %b %s %h",
				$time, what, got.berr, gt.name(), got.vector, exp.berr, et.name(), exp.vector);
		end
	endtask

	task automatic check_strobe(input logic got, input logic exp, input string what);
		mon_checks++;
		if (got !== exp) begin
			mon_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_ipl(input logic [2:0] got, input logic [2:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s ipl %b, expected %b", $time, what, got, exp);
		end
	endtask

	// watches done and compares each completion in order
	always @(negedge clk_32) begin
		if (!berr_reset) begin
			if (done) begin
				if (exp_q.size() == 0) begin
					mon_errors++;
					$display("done strobe at %0t with no access outstanding", $time);
				end else begin
					mon_exp = exp_q.pop_front();
					check_completion(result, mon_exp, "completion");
					check_strobe(mfp_iack, mon_exp.target == tgt_iack_mfp, "mfp_iack with done");
				end
			end else if (mfp_iack) begin
				mon_errors++;
				$display("mfp_iack strobed at %0t without a done", $time);
			end
		end
	end

	always @(posedge clk_32) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + mon_errors;
	endfunction

	function automatic st_config_t rand_config();
		st_config_t c;
		c.mem_size = mem_size_e'(3'($urandom % 6));
		c.ste      = 1'($urandom);
		c.mega_ste = 1'($urandom);
		c.steroids = 1'($urandom);
		c.ethernec = 1'($urandom);
		c.blitter  = 1'($urandom);
		c.fast_cpu = 1'($urandom);
		return c;
	endfunction

	// random access inside one of the map regions
	function automatic cpu_access_t rand_access();
		cpu_access_t a;
		logic [23:0] b;
		int          lanes;
		case ($urandom % 9)
			0: b = 24'($urandom % 8);
			1: b = 24'h000008 + 24'($urandom % 32'h3ffff8);
			2: b = 24'h400000 + 24'($urandom % 32'h400000);
			3: b = 24'h800000 + 24'($urandom % 32'h600000);
			4: b = 24'he00000 + 24'($urandom % 32'h040000);
			5: b = 24'he80000 + 24'($urandom % 32'h080000);
			6: b = 24'hfa0000 + 24'($urandom % 32'h020000);
			7: b = 24'hfc0000 + 24'($urandom % 32'h030000);
			default: b = {8'hff, IO_BASES[4'($urandom % 16)] + 16'(2 * ($urandom % 4))};
		endcase
		lanes   = $urandom % 3;
		a.addr  = b[23:1];
		a.uds_n = (lanes == 1);
		a.lds_n = (lanes == 2);
		a.rw    = 1'($urandom);
		a.fc    = ($urandom % 2 == 1) ? 3'd5 : 3'd1;
		if ($urandom % 16 == 0)
			a.busstate = bs_idle;
		else if (!a.rw)
			a.busstate = bs_write;
		else
			a.busstate = ($urandom % 4 == 0) ? bs_fetch : bs_read;
		return a;
	endfunction

	function automatic cpu_access_t word_access(input logic [23:0] b, input logic rd);
		cpu_access_t a;
		a.addr     = b[23:1];
		a.rw       = rd;
		a.uds_n    = 1'b0;
		a.lds_n    = 1'b0;
		a.fc       = 3'd5;
		a.busstate = rd ? bs_read : bs_write;
		return a;
	endfunction

	function automatic cpu_access_t iack_access(input logic [2:0] level);
		cpu_access_t a;
		a.addr     = {20'hfffff, level};
		a.rw       = 1'b1;
		a.uds_n    = 1'b1;
		a.lds_n    = 1'b0;
		a.fc       = 3'd7;
		a.busstate = bs_read;
		return a;
	endfunction

	// one request, optional bus_request hold, then wait for done
	// cycles counts negedges from request or release up to done
	task automatic run_access(input cpu_access_t a, input int hold, output int cyc);
		exp_q.push_back(ref_decode(cfg, a));
		access     = a;
		access_req = 1'b1;
		@(negedge clk_32);
		access_req = 1'b0;
		repeat (hold) begin
			if (done) begin
				errors++;
				$display("done appeared at %0t while bus_request was held high", $time);
			end
			@(negedge clk_32);
		end
		bus_request = 1'b0;
		cyc = 1;
		while (!done) begin
			@(negedge clk_32);
			cyc++;
		end
		// lets the monitor finish with this completion
		@(negedge clk_32);
	endtask

	task automatic berr_case(input logic [23:0] b, input logic rd);
		run_access(word_access(b, rd), 0, cycles);
		// 16 slot ends of 16 clocks, plus the request and done registers
		if (cycles < 15 * 16 || cycles > 16 * 16 + 1) begin
			errors++;
			$display("Error at %0t: bus error on %h after %0d cycles, expected 240 to 257",
				$time, b, cycles);
		end
	endtask

	task automatic pulse_blank(input logic vertical);
		if (vertical)
			st_vs = 1'b1;
		else
			st_hs = 1'b1;
		repeat (4) @(negedge clk_32);
		st_vs = 1'b0;
		st_hs = 1'b0;
		repeat (6) @(negedge clk_32);
		if (vertical)
			vbi_set = 1'b1;
		else
			hbi_set = 1'b1;
	endtask

	task automatic settle_ipl(input string what);
		repeat (4) @(negedge clk_32);
		check_ipl(ipl, ref_ipl(mfp_irq, vbi_set, hbi_set), what);
	endtask

	initial begin
		void'($urandom(32'h27c02261));
		berr_reset  = 1'b1;
		cfg         = '0;
		access_req  = 1'b0;
		access      = '0;
		bus_request = 1'b0;
		st_vs       = 1'b0;
		st_hs       = 1'b0;
		mfp_irq     = 1'b0;
		vbi_set     = 1'b0;
		hbi_set     = 1'b0;
		repeat (10) @(posedge clk_32);
		@(negedge clk_32);
		berr_reset = 1'b0;
		@(negedge clk_32);

		mark = total_errors();
		for (int i = 0; i < N_DECODE; i++) begin
			cfg = rand_config();
			run_access(rand_access(), 0, cycles);
		end
		$display("decode: %0d random accesses, %0d errors", N_DECODE, total_errors() - mark);

		// slow cpu, one cpu slot per 16 clocks
		mark = total_errors();
		cfg = '0;
		cfg.mem_size = mem_4m;
		berr_case(24'hfc0100, 1'b0);
		berr_case(24'h000004, 1'b0);
		berr_case(24'hff8100, 1'b1);
		berr_case(24'hf00000, 1'b1);
		$display("bus error: 4 unclaimed accesses, %0d errors", total_errors() - mark);

		mark = total_errors();
		cfg.ste = 1'b1;
		bus_request = 1'b1;
		run_access(word_access(24'h001000, 1'b1), HOLD, cycles);
		// the dtack timeout starts over once the bus is back
		bus_request = 1'b1;
		run_access(word_access(24'hff8100, 1'b1), HOLD, cycles);
		if (cycles < 15 * 16) begin
			errors++;
			$display("Error at %0t: bus error %0d cycles after bus_request dropped", $time, cycles);
		end
		$display("bus request: 2 held accesses, %0d errors", total_errors() - mark);

		mark = total_errors();
		settle_ipl("idle");
		mfp_irq = 1'b1;
		pulse_blank(1'b1);
		pulse_blank(1'b0);
		settle_ipl("mfp over vbi and hbi");
		mfp_irq = 1'b0;
		settle_ipl("vbi over hbi");
		$display("interrupt priority: %0d errors", total_errors() - mark);

		mark = total_errors();
		run_access(iack_access(3'd4), 0, cycles);
		vbi_set = 1'b0;
		settle_ipl("after vbi acknowledge");
		run_access(iack_access(3'd2), 0, cycles);
		hbi_set = 1'b0;
		settle_ipl("after hbi acknowledge");
		mfp_irq = 1'b1;
		run_access(iack_access(3'd6), 0, cycles);
		mfp_irq = 1'b0;
		settle_ipl("after mfp acknowledge");
		$display("acknowledge: 3 cycles, %0d errors", total_errors() - mark);

		$display("summary: %0d checks, %0d errors", checks + mon_checks, total_errors());
		if (total_errors() == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/st_bus_glue.sv ====
// st bus glue top
// slot sequencing, address decode, cpu bus cycles and interrupts
`timescale 1ns/1ps
`default_nettype none

module st_bus_glue
	import st_map_pkg::*;
	import st_bus_pkg::*;
(
	input  logic        clk_32,
	input  logic        berr_reset,
	input  st_config_t  cfg,
	input  logic        access_req,
	input  cpu_access_t access,
	input  logic        bus_request,
	input  logic        st_vs,
	input  logic        st_hs,
	input  logic        mfp_irq,
	output logic        done,
	output completion_t result,
	output logic [2:0]  ipl,
	output logic        mfp_iack
);

	slot_info_t  slot_info;
	// pending access as seen by the decoder
	cpu_access_t latched;
	target_e     target;

	slot_sequencer slot_sequencer_i (
		.clk_32     (clk_32),
		.berr_reset (berr_reset),
		.cfg        (cfg),
		.slot_info  (slot_info)
	);

	address_decoder address_decoder_i (
		.cfg    (cfg),
		.access (latched),
		.target (target)
	);

	bus_cycle_ctrl bus_cycle_ctrl_i (
		.clk_32      (clk_32),
		.berr_reset  (berr_reset),
		.slot_info   (slot_info),
		.access_req  (access_req),
		.access      (access),
		.bus_request (bus_request),
		.latched     (latched),
		.target      (target),
		.done        (done),
		.result      (result)
	);

	irq_encoder irq_encoder_i (
		.clk_32     (clk_32),
		.berr_reset (berr_reset),
		.st_vs      (st_vs),
		.st_hs      (st_hs),
		.mfp_irq    (mfp_irq),
		.done       (done),
		.result     (result),
		.ipl        (ipl),
		.mfp_iack   (mfp_iack)
	);

endmodule

`default_nettype wire

// ==== logic/irq_encoder.sv ====
// interrupt encoder
// latches vertical and horizontal blank edges, clears them on their
// acknowledge and drives ipl with mfp above vbi above hbi
`timescale 1ns/1ps
`default_nettype none
`include "st_consts.svh"

module irq_encoder
	import st_map_pkg::*;
	import st_bus_pkg::*;
(
	input  logic        clk_32,
	input  logic        berr_reset,
	input  logic        st_vs,
	input  logic        st_hs,
	input  logic        mfp_irq,
	input  logic        done,
	input  completion_t result,
	output logic [2:0]  ipl,
	output logic        mfp_iack
);

	logic vs_d1;
	logic vs_d2;
	logic hs_d1;
	logic hs_d2;
	logic vbi;
	logic hbi;
	logic vbi_ack;
	logic hbi_ack;

	assign vbi_ack = done && (result.target == tgt_iack_vbi);
	assign hbi_ack = done && (result.target == tgt_iack_hbi);

	// the mfp acts on the rising edge of iack, so this is the registered done
	assign mfp_iack = done && (result.target == tgt_iack_mfp);

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			hs_d1 <= 1'b0;
			hs_d2 <= 1'b0;
			vbi   <= 1'b0;
			hbi   <= 1'b0;
			ipl   <= `ST_IPL_NONE;
		end else begin
			vs_d1 <= st_vs;
			vs_d2 <= vs_d1;
			hs_d1 <= st_hs;
			hs_d2 <= hs_d1;
			// acknowledge wins over a new edge in the same cycle
			if (vbi_ack)
				vbi <= 1'b0;
			else if (vs_d1 && !vs_d2)
				vbi <= 1'b1;
			if (hbi_ack)
				hbi <= 1'b0;
			else if (hs_d1 && !hs_d2)
				hbi <= 1'b1;
			// mfp is level 6, vbi level 4, hbi level 2
			if (mfp_irq)
				ipl <= `ST_IPL_MFP;
			else if (vbi)
				ipl <= `ST_IPL_VBI;
			else if (hbi)
				ipl <= `ST_IPL_HBI;
			else
				ipl <= `ST_IPL_NONE;
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_cycle_ctrl.sv ====
// bus cycle controller
// holds the pending cpu access, completes it in a free cpu slot and
// raises a bus error after the dtack timeout
`timescale 1ns/1ps
`default_nettype none
`include "st_consts.svh"

module bus_cycle_ctrl
	import st_map_pkg::*;
	import st_bus_pkg::*;
(
	input  logic        clk_32,
	input  logic        berr_reset,
	input  slot_info_t  slot_info,
	input  logic        access_req,
	input  cpu_access_t access,
	input  logic        bus_request,
	output cpu_access_t latched,
	input  target_e     target,
	output logic        done,
	output completion_t result
);

	logic       pending;
	logic [3:0] timeout_cnt;
	logic       is_idle;
	logic       claimed;
	logic       timed_out;
	logic       finish;
	target_e    done_target;
	logic [7:0] done_vector;

	// internal cpu cycle, nothing on the bus to claim it
	assign is_idle   = (latched.busstate == bs_idle);
	assign claimed   = (target != tgt_none);
	assign timed_out = (timeout_cnt == `ST_TIMEOUT_LIMIT);

	// another master owning the bus holds the cpu off
	assign finish = pending && slot_info.cpu_slot_end && !bus_request &&
		(claimed || is_idle || timed_out);

	assign done_target = is_idle ? tgt_none : target;

	// autovectors for the blank interrupts
	always_comb begin
		case (done_target)
			tgt_iack_vbi: done_vector = `ST_VEC_VBI;
			tgt_iack_hbi: done_vector = `ST_VEC_HBI;
			default:      done_vector = 8'h00;
		endcase
	end

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			pending     <= 1'b0;
			timeout_cnt <= 4'd0;
			done        <= 1'b0;
		end else begin
			done <= finish;
			if (access_req)
				pending <= 1'b1;
			else if (finish)
				pending <= 1'b0;
			// a bus owned by another master counts as bus ok
			if (access_req || bus_request)
				timeout_cnt <= 4'd0;
			else if (pending && slot_info.cpu_slot_end && !claimed && !is_idle && !timed_out)
				timeout_cnt <= timeout_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			latched <= '0;
			result  <= '0;
		end else begin
			if (access_req)
				latched <= access;
			if (finish) begin
				// only a timed out access reaches here unclaimed
				result.berr   <= !claimed && !is_idle;
				result.target <= done_target;
				result.vector <= done_vector;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/address_decoder.sv ====
// address decoder
// classifies a latched cpu access into a memory or i/o target,
// depending on memory size and the ste, mega ste and steroids features
`timescale 1ns/1ps
`default_nettype none
`include "st_consts.svh"

module address_decoder
	import st_map_pkg::*;
	import st_bus_pkg::*;
(
	input  st_config_t  cfg,
	input  cpu_access_t access,
	output target_e     target
);

	logic [23:0] badr;
	logic [15:0] ofs;
	logic        mem_8m_up;
	logic        low_rom;
	logic        rom_hit;
	logic        ram_hit;
	logic        cart_page;
	logic        io_page;
	logic        word_access;
	logic        mste_regs;
	target_e     io_target;

	// true when a lies in [base, base + size)
	function automatic logic in_win(input logic [15:0] a, input logic [15:0] base,
		input logic [15:0] size);
		in_win = (a >= base) && (a < base + size);
	endfunction

	// byte address, bit 0 never reaches the bus
	assign badr = {access.addr, 1'b0};
	assign ofs  = badr[15:0];

	assign mem_8m_up   = (cfg.mem_size == mem_8m) || (cfg.mem_size == mem_14m);
	assign word_access = !access.uds_n && !access.lds_n;
	// steroids runs full speed and has no mega ste speed registers
	assign mste_regs   = cfg.mega_ste && !cfg.steroids;

	// reset vector rom at $000000-$000007
	assign low_rom = (badr[23:3] == 21'd0);

	// 256k tos at $e00000, 192k tos at $fc0000-$feffff
	assign rom_hit = low_rom ||
		(badr[23:18] == `ST_TOS256_BASE) ||
		(badr[23:17] == `ST_TOS192_LO) ||
		(badr[23:16] == `ST_TOS192_HI);

	// base 4 mb always there, more with larger configurations
	assign ram_hit = !low_rom && (
		(badr[23:22] == 2'b00) ||
		(mem_8m_up && (badr[23:22] == 2'b01)) ||
		((cfg.mem_size == mem_14m) && ((badr[23:22] == 2'b10) || (badr[23:21] == 3'b110))) ||
		(cfg.steroids && (badr[23:19] == `ST_STEROIDS_RAM)));

	// $fa0000-$fbffff
	assign cart_page = (badr[23:17] == `ST_CART_PAGE);
	assign io_page   = (badr[23:16] == `ST_IO_PAGE);

	// i/o register windows inside the $ff page
	always_comb begin
		io_target = tgt_none;
		if (in_win(ofs, `ST_IO_MMU, 16'h000e))
			io_target = tgt_mmu;
		else if (in_win(ofs, `ST_IO_SHIFTER, 16'h000e) ||
			(cfg.ste && in_win(ofs, `ST_IO_SHIFTER + 16'h000e, 16'h0002)) ||
			in_win(ofs, `ST_IO_PALETTE, 16'h0040))
			io_target = tgt_shifter;
		// sector count word needs both strobes
		else if ((word_access && in_win(ofs, `ST_IO_DMA, 16'h0004)) ||
			in_win(ofs, `ST_IO_DMA + 16'h0004, 16'h0006) ||
			(cfg.ste && in_win(ofs, `ST_IO_DMA + 16'h000a, 16'h0002)))
			io_target = tgt_dma;
		else if (in_win(ofs, `ST_IO_PSG, 16'h0100))
			io_target = tgt_psg;
		else if (cfg.ste && in_win(ofs, `ST_IO_STE_SND, 16'h0040))
			io_target = tgt_ste_snd;
		// every ste carries a blitter
		else if ((cfg.blitter || cfg.ste) && in_win(ofs, `ST_IO_BLITTER, 16'h0040))
			io_target = tgt_blitter;
		else if (mste_regs && in_win(ofs, `ST_IO_MSTE_CTRL, 16'h0002))
			io_target = tgt_mste_ctrl;
		else if (mste_regs && in_win(ofs, `ST_IO_VME, 16'h0010))
			io_target = tgt_vme;
		else if (cfg.ste && in_win(ofs, `ST_IO_STE_JOY, 16'h0040))
			io_target = tgt_ste_joy;
		// mfp sits on the odd byte lane
		else if (!access.lds_n && in_win(ofs, `ST_IO_MFP, 16'h0040))
			io_target = tgt_mfp;
		else if (in_win(ofs, `ST_IO_ACIA, 16'h0200))
			io_target = tgt_acia;
	end

	always_comb begin
		target = tgt_none;
		if (access.fc == `ST_FC_IACK) begin
			// acknowledge level sits in address bits 3:1
			case (access.addr[2:0])
				`ST_IACK_MFP: target = tgt_iack_mfp;
				`ST_IACK_VBI: target = tgt_iack_vbi;
				`ST_IACK_HBI: target = tgt_iack_hbi;
				default:      target = tgt_none;
			endcase
		end else if (rom_hit) begin
			// rom writes stay unclaimed and run into a bus error
			if (access.rw)
				target = tgt_rom;
		end else if (ram_hit) begin
			target = tgt_ram;
		end else if (cart_page) begin
			if (access.rw)
				target = cfg.ethernec ? tgt_romport : tgt_rom;
		end else if (io_page) begin
			target = io_target;
		end
	end

endmodule

`default_nettype wire

// ==== logic/slot_sequencer.sv ====
// slot sequencer
// divides clk_32 into 8 mhz phases and a four slot bus cycle,
// flags the end of each cpu slot
`timescale 1ns/1ps
`default_nettype none
`include "st_consts.svh"

module slot_sequencer
	import st_map_pkg::*;
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       berr_reset,
	input  st_config_t cfg,
	output slot_info_t slot_info
);

	// phase stands in for clkcnt, slot for bus_cycle
	logic [1:0] phase;
	logic [1:0] slot;
	logic       last_phase;
	logic       in_cpu_slot;

	assign last_phase = (phase == `ST_PHASE_LAST);

	// slots 0 and 2 belong to video
	// slot 3 is a cpu slot only in fast mode
	assign in_cpu_slot = (slot == `ST_SLOT_CPU) ||
		(cfg.fast_cpu && (slot == `ST_SLOT_CPU2));

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			phase <= 2'd0;
			slot  <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
			// next slot once the four phases are through
			if (last_phase)
				slot <= slot + 2'd1;
		end
	end

	always_comb begin
		slot_info.phase        = phase;
		slot_info.slot         = slot;
		slot_info.cpu_slot_end = last_phase && in_cpu_slot;
	end

endmodule

`default_nettype wire

// ==== logic/st_bus_pkg.sv ====
// bus transaction types
// cpu access, bus state, completion and bus cycle position
`default_nettype none

package st_bus_pkg;

	import st_map_pkg::*;

	// cpu bus state, same coding as the cpu core
	typedef enum logic [1:0] {
		bs_fetch = 2'b00,
		bs_idle  = 2'b01,
		bs_read  = 2'b10,
		bs_write = 2'b11
	} busstate_e;

	// one cpu access as latched for the 8 mhz bus
	typedef struct packed {
		// word address, byte address bits 23:1
		logic [22:0] addr;
		// high for read
		logic        rw;
		logic        uds_n;
		logic        lds_n;
		logic [2:0]  fc;
		busstate_e   busstate;
	} cpu_access_t;

	// position in the four slot bus cycle
	typedef struct packed {
		logic [1:0] phase;
		logic [1:0] slot;
		// last clock of a cpu slot
		logic       cpu_slot_end;
	} slot_info_t;

	// result handed back with done
	typedef struct packed {
		logic       berr;
		target_e    target;
		// autovector byte, zero when none applies
		logic [7:0] vector;
	} completion_t;

endpackage

`default_nettype wire

// ==== logic/st_map_pkg.sv ====
// machine description types
// memory size, feature configuration and decoded bus targets
`default_nettype none

package st_map_pkg;

	// installed st ram
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_e;

	// feature bits of the emulated machine
	typedef struct packed {
		mem_size_e mem_size;
		logic      ste;
		logic      mega_ste;
		// ste on steroids, no mega ste cache control
		logic      steroids;
		logic      ethernec;
		logic      blitter;
		// enables the second cpu slot
		logic      fast_cpu;
	} st_config_t;

	// what an access lands on
	typedef enum logic [4:0] {
		tgt_none,
		tgt_ram,
		tgt_rom,
		tgt_romport,
		tgt_mmu,
		tgt_shifter,
		tgt_dma,
		tgt_psg,
		tgt_ste_snd,
		tgt_blitter,
		tgt_vme,
		tgt_mste_ctrl,
		tgt_ste_joy,
		tgt_mfp,
		tgt_acia,
		tgt_iack_hbi,
		tgt_iack_vbi,
		tgt_iack_mfp
	} target_e;

endpackage

`default_nettype wire

// ==== include/st_consts.svh ====
// bus glue constants
// memory map regions, i/o register offsets, slot positions, timeout,
// autovectors and ipl codes of the st class machine
`ifndef ST_CONSTS_SVH
`define ST_CONSTS_SVH

// bus cycle positions within clk_32
`define ST_PHASE_LAST   2'd3
`define ST_SLOT_CPU     2'd1
`define ST_SLOT_CPU2    2'd3

// region bases, compared against the upper byte address bits
`define ST_TOS256_BASE  6'b111000
`define ST_TOS192_LO    7'b1111110
`define ST_TOS192_HI    8'hfe
`define ST_STEROIDS_RAM 5'b11101
`define ST_CART_PAGE    7'b1111101
`define ST_IO_PAGE      8'hff

// i/o offsets within the $ffxxxx page
`define ST_IO_MMU       16'h8000
`define ST_IO_SHIFTER   16'h8200
`define ST_IO_PALETTE   16'h8240
`define ST_IO_DMA       16'h8604
`define ST_IO_PSG       16'h8800
`define ST_IO_STE_SND   16'h8900
`define ST_IO_BLITTER   16'h8a00
`define ST_IO_VME       16'h8e00
`define ST_IO_MSTE_CTRL 16'h8e20
`define ST_IO_STE_JOY   16'h9200
`define ST_IO_MFP       16'hfa00
`define ST_IO_ACIA      16'hfc00

// interrupt acknowledge cycles
`define ST_FC_IACK      3'b111
`define ST_IACK_MFP     3'd6
`define ST_IACK_VBI     3'd4
`define ST_IACK_HBI     3'd2

// unclaimed cpu slots before bus error
`define ST_TIMEOUT_LIMIT 4'd15

// autovector bytes for blank interrupts
`define ST_VEC_VBI      8'h1c
`define ST_VEC_HBI      8'h1a

// ipl codes, active low, ipl[0] stays high on the st
`define ST_IPL_NONE     3'b111
`define ST_IPL_HBI      3'b101
`define ST_IPL_VBI      3'b011
`define ST_IPL_MFP      3'b001

`endif
